/* logic/core_pkg.sv */
// core package: widths, opcode enum, branch bus and stage payload structs
`default_nettype none

package core_pkg;

  localparam int XLEN         = 32;
  localparam int INST_WD      = 32;
  localparam int SRAM_DATA_WD = 64; // two instructions per memory word
  localparam int SRAM_ADDR_WD = 32;
  localparam int REG_AW       = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // anything the decoder does not know becomes OP_NOP
  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_JAL
  } op_e;

  typedef struct packed {
    logic  stall;  // branch held in decode on a source
    logic  taken;
    word_t target;
  } br_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    word_t              pc;
  } fs_ds_t;

  typedef struct packed {
    op_e      op;
    word_t    pc;
    word_t    src1;
    word_t    src2; // immediate already merged in
    reg_idx_t dest; // zero when nothing is written
  } ds_es_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t dest;
    word_t    value;
  } es_rs_t;

endpackage

`default_nettype wire

/* logic/stage_if.sv */
// valid/allowin interfaces between fetch, decode, execute and result
`default_nettype none

interface fs_ds_if;
  import core_pkg::*;

  logic   valid;
  logic   allowin;
  fs_ds_t bus;

  modport src (output valid, output bus, input allowin);
  modport dst (input valid, input bus, output allowin);
endinterface

interface ds_es_if;
  import core_pkg::*;

  logic   valid;
  logic   allowin;
  ds_es_t bus;

  modport src (output valid, output bus, input allowin);
  modport dst (input valid, input bus, output allowin);
endinterface

// last hop, result side always takes
interface es_rs_if;
  import core_pkg::*;

  logic   valid;
  logic   allowin;
  es_rs_t bus;

  modport src (output valid, output bus, input allowin);
  modport dst (input valid, input bus, output allowin);
endinterface

`default_nettype wire

/* logic/regfile.sv */
// register file: 32 x 32 bits, two combinational reads, one write, x0 reads zero
`default_nettype none

module regfile (
  input  logic               i_clk,
  input  logic               i_we,
  input  core_pkg::reg_idx_t i_waddr,
  input  core_pkg::word_t    i_wdata,
  input  core_pkg::reg_idx_t i_raddr1,
  input  core_pkg::reg_idx_t i_raddr2,
  output core_pkg::word_t    o_rdata1,
  output core_pkg::word_t    o_rdata2
);
  import core_pkg::*;

  word_t rf [2**REG_AW]; // entry 0 is never written

  always_ff @(posedge i_clk) begin
    if (i_we && i_waddr != '0) rf[i_waddr] <= i_wdata;
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : rf[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : rf[i_raddr2];

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
// fetch stage: pre-fetch request, pc register, fetch valid, instruction buffer, half select
`default_nettype none

module fetch_stage #(
  parameter core_pkg::word_t PC_RESETVAL = '0
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  core_pkg::br_bus_t                 i_br_bus,
  output logic                              o_inst_sram_ren,
  output logic [core_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [core_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                              i_inst_sram_addr_ok,
  input  logic                              i_inst_sram_data_ok,
  fs_ds_if.src                              fs_ds
);
  import core_pkg::*;

  logic               fs_run;   // low in reset and the cycle after
  word_t              pc;       // pc of the request held in fetch
  logic               pc_first; // nothing requested since reset
  logic               fs_valid;
  logic               fs_ready_go;
  logic               fs_allowin;
  logic               req_fire;
  logic               redir_now;
  word_t              redir_tgt;
  word_t              seq_pc;
  word_t              req_pc;
  logic               bp_valid; // taken branch waiting for its redirect
  logic               bp_slot;  // its delay slot has been requested
  word_t              bp_target;
  logic               buf_valid;
  logic               buf_we;
  logic [INST_WD-1:0] buf_inst;
  logic [INST_WD-1:0] fs_inst;

  assign fs_ready_go = i_inst_sram_data_ok | buf_valid;
  assign fs_allowin  = !fs_valid | (fs_ready_go & fs_ds.allowin);

  // a live fetch behind the branch means the delay slot is already out
  assign redir_now = bp_valid ? bp_slot : (i_br_bus.taken & fs_valid);
  assign redir_tgt = bp_valid ? bp_target : i_br_bus.target;
  assign seq_pc    = pc_first ? pc : pc + 32'd4;
  assign req_pc    = redir_now ? redir_tgt : seq_pc;

  assign o_inst_sram_ren  = fs_run & fs_allowin & !i_br_bus.stall;
  assign o_inst_sram_addr = req_pc;
  assign req_fire         = o_inst_sram_ren & i_inst_sram_addr_ok;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_run   <= 1'b0;
      fs_valid <= 1'b0;
      pc       <= PC_RESETVAL;
      pc_first <= 1'b1;
    end else begin
      fs_run <= 1'b1;
      if (fs_allowin) fs_valid <= req_fire;
      if (req_fire) begin
        pc       <= req_pc;
        pc_first <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      bp_valid <= 1'b0;
      bp_slot  <= 1'b0;
    end else if (bp_valid) begin
      if (req_fire && bp_slot) bp_valid <= 1'b0;
      else if (req_fire) bp_slot <= 1'b1;
    end else if (i_br_bus.taken && !(req_fire && fs_valid)) begin
      bp_valid <= 1'b1;
      bp_slot  <= fs_valid | req_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!bp_valid && i_br_bus.taken) bp_target <= i_br_bus.target;
  end

  // pc[2] picks the half of the 64-bit word
  assign fs_inst = pc[2] ? i_inst_sram_rdata[63:32] : i_inst_sram_rdata[31:0];

  assign buf_we = i_inst_sram_data_ok & !fs_ds.allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) buf_valid <= 1'b0;
    else if (fs_ds.allowin) buf_valid <= 1'b0;
    else if (buf_we) buf_valid <= 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (buf_we) buf_inst <= fs_inst;
  end

  assign fs_ds.valid = fs_valid & fs_ready_go;
  assign fs_ds.bus   = '{inst: (buf_valid ? buf_inst : fs_inst), pc: pc};

  // a second response while one is parked would be lost
  a_buf_no_overwrite: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    buf_we |-> !buf_valid);

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// decode stage: instruction decode, register read, hazard stall, branch resolution
`default_nettype none

module decode_stage (
  input  logic               i_clk,
  input  logic               i_rst_n,
  fs_ds_if.dst               fs_ds,
  ds_es_if.src               ds_es,
  output core_pkg::br_bus_t  o_br_bus,
  input  core_pkg::reg_idx_t i_es_dest,
  input  core_pkg::reg_idx_t i_rs_dest,
  input  logic               i_rf_we,
  input  core_pkg::reg_idx_t i_rf_waddr,
  input  core_pkg::word_t    i_rf_wdata
);
  import core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic               ds_valid;
  fs_ds_t             ds_r;
  logic               ds_ready_go;
  logic               ds_allowin;
  logic [INST_WD-1:0] inst;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  reg_idx_t           rs1;
  reg_idx_t           rs2;
  reg_idx_t           rd;
  op_e                op;
  logic               use_rs1;
  logic               use_rs2;
  logic               has_rd;
  word_t              imm_i;
  word_t              imm_u;
  word_t              imm_b;
  word_t              imm_j;
  word_t              rdata1;
  word_t              rdata2;
  word_t              src2;
  logic               hazard;
  logic               is_br;
  logic               br_cond;

  assign inst   = ds_r.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  always_comb begin
    op = OP_NOP;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = OP_ADD;
            3'b100:  op = OP_XOR;
            3'b110:  op = OP_OR;
            3'b111:  op = OP_AND;
            default: op = OP_NOP;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = OP_SUB;
        end
      end
      OPC_OP_IMM: if (funct3 == 3'b000) op = OP_ADDI;
      OPC_LUI:    op = OP_LUI;
      OPC_BRANCH: begin
        if (funct3 == 3'b000) op = OP_BEQ;
        else if (funct3 == 3'b001) op = OP_BNE;
      end
      OPC_JAL:    op = OP_JAL;
      default:    op = OP_NOP;
    endcase
  end

  assign use_rs1 = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_BEQ, OP_BNE};
  assign use_rs2 = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_BEQ, OP_BNE};
  assign has_rd  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI, OP_JAL};
  assign is_br   = op inside {OP_BEQ, OP_BNE, OP_JAL};

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  regfile u_regfile (
    .i_clk    (i_clk),
    .i_we     (i_rf_we),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2)
  );

  // no forwarding, so wait until the producer has left result
  assign hazard = (use_rs1 && rs1 != '0 && (rs1 == i_es_dest || rs1 == i_rs_dest)) ||
                  (use_rs2 && rs2 != '0 && (rs2 == i_es_dest || rs2 == i_rs_dest));

  assign src2 = use_rs2 ? rdata2 : ((op == OP_LUI) ? imm_u : imm_i);

  assign br_cond = (op == OP_BEQ && rdata1 == rdata2) ||
                   (op == OP_BNE && rdata1 != rdata2) ||
                   (op == OP_JAL);

  assign o_br_bus.stall  = ds_valid & is_br & !ds_ready_go;
  assign o_br_bus.taken  = ds_valid & ds_ready_go & br_cond;
  assign o_br_bus.target = ds_r.pc + ((op == OP_JAL) ? imm_j : imm_b);

  assign ds_ready_go   = !hazard;
  assign ds_allowin    = !ds_valid | (ds_ready_go & ds_es.allowin);
  assign fs_ds.allowin = ds_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) ds_valid <= 1'b0;
    else if (ds_allowin) ds_valid <= fs_ds.valid;
  end

  always_ff @(posedge i_clk) begin
    if (fs_ds.valid && ds_allowin) ds_r <= fs_ds.bus;
  end

  assign ds_es.valid = ds_valid & ds_ready_go;
  assign ds_es.bus   = '{op: op, pc: ds_r.pc, src1: rdata1, src2: src2,
                         dest: (has_rd ? rd : '0)};

  // fetch sees taken for one cycle only
  a_br_taken_not_stalled: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_bus.taken |-> (!o_br_bus.stall && ds_es.allowin));

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// execute stage: ALU and JAL link value
`default_nettype none

module execute_stage (
  input  logic               i_clk,
  input  logic               i_rst_n,
  ds_es_if.dst               ds_es,
  es_rs_if.src               es_rs,
  output core_pkg::reg_idx_t o_es_dest
);
  import core_pkg::*;

  logic   es_valid;
  ds_es_t es_r;
  logic   es_allowin;
  word_t  result;

  // single cycle, so ready_go is always high
  assign es_allowin    = !es_valid | es_rs.allowin;
  assign ds_es.allowin = es_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) es_valid <= 1'b0;
    else if (es_allowin) es_valid <= ds_es.valid;
  end

  always_ff @(posedge i_clk) begin
    if (ds_es.valid && es_allowin) es_r <= ds_es.bus;
  end

  always_comb begin
    case (es_r.op)
      OP_ADD, OP_ADDI: result = es_r.src1 + es_r.src2;
      OP_SUB:          result = es_r.src1 - es_r.src2;
      OP_AND:          result = es_r.src1 & es_r.src2;
      OP_OR:           result = es_r.src1 | es_r.src2;
      OP_XOR:          result = es_r.src1 ^ es_r.src2;
      OP_LUI:          result = es_r.src2; // upper immediate from decode
      OP_JAL:          result = es_r.pc + 32'd4;
      default:         result = '0;        // branches and nops
    endcase
  end

  assign es_rs.valid = es_valid;
  assign es_rs.bus   = '{pc: es_r.pc, dest: es_r.dest, value: result};

  assign o_es_dest = es_valid ? es_r.dest : '0;

endmodule

`default_nettype wire

/* logic/result_stage.sv */
// result stage: register file write and retirement report
`default_nettype none

module result_stage (
  input  logic               i_clk,
  input  logic               i_rst_n,
  es_rs_if.dst               es_rs,
  output core_pkg::reg_idx_t o_rs_dest,
  output logic               o_rf_we,
  output core_pkg::reg_idx_t o_rf_waddr,
  output core_pkg::word_t    o_rf_wdata,
  output logic               o_wb_valid,
  output core_pkg::word_t    o_wb_pc,
  output core_pkg::reg_idx_t o_wb_dest,
  output core_pkg::word_t    o_wb_value
);
  import core_pkg::*;

  logic   rs_valid;
  es_rs_t rs_r;

  assign es_rs.allowin = 1'b1; // last stage never backs up

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) rs_valid <= 1'b0;
    else rs_valid <= es_rs.valid;
  end

  always_ff @(posedge i_clk) begin
    if (es_rs.valid) rs_r <= es_rs.bus;
  end

  assign o_rs_dest  = rs_valid ? rs_r.dest : '0;
  assign o_rf_we    = rs_valid & (rs_r.dest != '0);
  assign o_rf_waddr = rs_r.dest;
  assign o_rf_wdata = rs_r.value;

  // every retirement, writes or not
  assign o_wb_valid = rs_valid;
  assign o_wb_pc    = rs_r.pc;
  assign o_wb_dest  = rs_r.dest;
  assign o_wb_value = rs_r.value;

  a_we_retires: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rf_we |-> (o_wb_valid && o_wb_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

/* logic/core_top.sv */
// core top: four pipeline stages, stage interfaces and their wiring
`default_nettype none

module core_top #(
  parameter core_pkg::word_t PC_RESETVAL = 32'h0000_0000
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  output logic                              o_inst_sram_ren,
  output logic [core_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [core_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                              i_inst_sram_addr_ok,
  input  logic                              i_inst_sram_data_ok,
  output logic                              o_wb_valid,
  output core_pkg::word_t                   o_wb_pc,
  output core_pkg::reg_idx_t                o_wb_dest,
  output core_pkg::word_t                   o_wb_value
);
  import core_pkg::*;

  br_bus_t  br_bus;
  reg_idx_t es_dest;
  reg_idx_t rs_dest;
  logic     rf_we;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  fs_ds_if fs_ds ();
  ds_es_if ds_es ();
  es_rs_if es_rs ();

  fetch_stage #(
    .PC_RESETVAL (PC_RESETVAL)
  ) u_fetch_stage (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_br_bus            (br_bus),
    .o_inst_sram_ren     (o_inst_sram_ren),
    .o_inst_sram_addr    (o_inst_sram_addr),
    .i_inst_sram_rdata   (i_inst_sram_rdata),
    .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
    .i_inst_sram_data_ok (i_inst_sram_data_ok),
    .fs_ds               (fs_ds.src)
  );

  decode_stage u_decode_stage (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .fs_ds      (fs_ds.dst),
    .ds_es      (ds_es.src),
    .o_br_bus   (br_bus),
    .i_es_dest  (es_dest),  // hazard check
    .i_rs_dest  (rs_dest),
    .i_rf_we    (rf_we),
    .i_rf_waddr (rf_waddr),
    .i_rf_wdata (rf_wdata)
  );

  execute_stage u_execute_stage (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .ds_es     (ds_es.dst),
    .es_rs     (es_rs.src),
    .o_es_dest (es_dest)
  );

  result_stage u_result_stage (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .es_rs      (es_rs.dst),
    .o_rs_dest  (rs_dest),
    .o_rf_we    (rf_we),
    .o_rf_waddr (rf_waddr),
    .o_rf_wdata (rf_wdata),
    .o_wb_valid (o_wb_valid),
    .o_wb_pc    (o_wb_pc),
    .o_wb_dest  (o_wb_dest),
    .o_wb_value (o_wb_value)
  );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// testbench clock and reset generator
`default_nettype none

module tb_clock (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    forever #5 o_clk = ~o_clk; // 10 ns period
  end

  initial begin
    repeat (16) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/inst_mem.sv */
// instruction memory model: program table, random addr_ok and data_ok latency
`default_nettype none

module inst_mem (
  input  logic                              i_clk,
  input  logic                              i_ren,
  input  logic [core_pkg::SRAM_ADDR_WD-1:0] i_addr,
  output logic [core_pkg::SRAM_DATA_WD-1:0] o_rdata,
  output logic                              o_addr_ok,
  output logic                              o_data_ok
);
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam int DEPTH = 64; // instructions

  logic [31:0] prog [DEPTH];
  integer      seed;
  int          addr_cnt;
  int          data_cnt;
  logic        pending;
  logic        take_addr;
  logic        take_data;
  logic        ren_seen;
  logic [31:0] acc_addr;
  logic [31:0] req_addr;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic int rand_delay();
    return int'($unsigned($random(seed)) % 32'd4);
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr[7:3]) * 2;
    return {prog[idx+1], prog[idx]};
  endfunction

  initial begin
    // unused slots hold addi x0,x0,index, harmless if ever fetched
    for (int i = 0; i < DEPTH; i++) prog[i] = enc_addi(5'd0, 5'd0, 12'(i));
    prog['h00/4] = enc_addi(5'd1, 5'd0, 12'd5);
    prog['h04/4] = enc_addi(5'd2, 5'd0, -12'sd3);
    prog['h08/4] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);  // add
    prog['h0c/4] = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);  // sub
    prog['h10/4] = enc_lui(5'd5, 20'h12345);
    prog['h14/4] = enc_addi(5'd5, 5'd5, 12'h678);
    prog['h18/4] = enc_r(7'h00, 5'd4, 5'd5, 3'b111, 5'd6);  // and
    prog['h1c/4] = enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd7);  // or
    prog['h20/4] = enc_r(7'h00, 5'd1, 5'd5, 3'b100, 5'd8);  // xor
    prog['h24/4] = enc_r(7'h20, 5'd1, 5'd0, 3'b000, 5'd9);
    prog['h28/4] = enc_br(3'b000, 5'd1, 5'd1, 13'd16);     // beq taken
    prog['h2c/4] = enc_addi(5'd10, 5'd0, 12'd1);
    prog['h30/4] = enc_addi(5'd11, 5'd0, 12'd99);
    prog['h34/4] = enc_addi(5'd12, 5'd0, 12'd99);
    prog['h38/4] = enc_br(3'b001, 5'd1, 5'd2, 13'd12);     // bne taken
    prog['h3c/4] = enc_addi(5'd13, 5'd10, 12'd7);
    prog['h40/4] = enc_addi(5'd14, 5'd0, 12'd99);
    prog['h44/4] = enc_br(3'b000, 5'd1, 5'd2, 13'd8);      // beq not taken
    prog['h48/4] = enc_addi(5'd15, 5'd0, 12'd10);
    prog['h4c/4] = enc_br(3'b001, 5'd3, 5'd3, 13'd8);      // bne not taken
    prog['h50/4] = enc_r(7'h00, 5'd13, 5'd15, 3'b000, 5'd16);
    prog['h54/4] = enc_jal(5'd17, 21'd12);
    prog['h58/4] = enc_addi(5'd18, 5'd0, 12'd33);
    prog['h5c/4] = enc_addi(5'd19, 5'd0, 12'd99);
    prog['h60/4] = enc_r(7'h00, 5'd18, 5'd17, 3'b000, 5'd20);
    prog['h64/4] = enc_jal(5'd0, 21'd0);                   // spin here
    prog['h68/4] = enc_addi(5'd0, 5'd0, 12'd0);
  end

  initial begin
    seed      = 18357;
    o_addr_ok = 1'b0;
    o_data_ok = 1'b0;
    o_rdata   = '0;
    pending   = 1'b0;
    data_cnt  = 0;
    req_addr  = '0;
    acc_addr  = '0;
    addr_cnt  = rand_delay();
    forever begin
      @(negedge i_clk);
      ren_seen  = i_ren;
      take_data = o_data_ok;
      take_addr = i_ren & o_addr_ok;
      if (take_addr) acc_addr = i_addr;
      @(posedge i_clk);
      #1;
      if (take_data) pending = 1'b0;
      else if (pending && data_cnt != 0) data_cnt = data_cnt - 1;
      if (take_addr) begin
        pending  = 1'b1; // one request outstanding at most
        req_addr = acc_addr;
        data_cnt = rand_delay();
        addr_cnt = rand_delay();
      end else if (ren_seen && addr_cnt != 0) begin
        addr_cnt = addr_cnt - 1;
      end
      o_addr_ok = (addr_cnt == 0);
      o_data_ok = pending && (data_cnt == 0);
      o_rdata   = o_data_ok ? read_word(req_addr) : '0;
    end
  end

endmodule

`default_nettype wire

/* test/core_tb.sv */
// testbench top: core instance, expected retirement table, compare tasks, watchdog
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam int NUM_EXP = 23;

  logic                    clk;
  logic                    rst_n;
  logic                    ren;
  logic [SRAM_ADDR_WD-1:0] addr;
  logic [SRAM_DATA_WD-1:0] rdata;
  logic                    addr_ok;
  logic                    data_ok;
  logic                    wb_valid;
  word_t                   wb_pc;
  reg_idx_t                wb_dest;
  word_t                   wb_value;

  word_t    exp_pc    [NUM_EXP];
  reg_idx_t exp_dest  [NUM_EXP];
  word_t    exp_value [NUM_EXP];
  int       n_exp;

  tb_clock u_clock (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  inst_mem u_mem (
    .i_clk     (clk),
    .i_ren     (ren),
    .i_addr    (addr),
    .o_rdata   (rdata),
    .o_addr_ok (addr_ok),
    .o_data_ok (data_ok)
  );

  core_top #(
    .PC_RESETVAL (32'h0000_0000)
  ) UUT (
    .i_clk               (clk),
    .i_rst_n             (rst_n),
    .o_inst_sram_ren     (ren),
    .o_inst_sram_addr    (addr),
    .i_inst_sram_rdata   (rdata),
    .i_inst_sram_addr_ok (addr_ok),
    .i_inst_sram_data_ok (data_ok),
    .o_wb_valid          (wb_valid),
    .o_wb_pc             (wb_pc),
    .o_wb_dest           (wb_dest),
    .o_wb_value          (wb_value)
  );

  task automatic add_expect(input word_t pc, input reg_idx_t dest, input word_t value);
    exp_pc[n_exp]    = pc;
    exp_dest[n_exp]  = dest;
    exp_value[n_exp] = value;
    n_exp = n_exp + 1;
  endtask

  task automatic check_pc(input int idx, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR @%0t: retirement %0d pc %h, expected %h", $time, idx, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_dest(input int idx, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("ERROR @%0t: retirement %0d dest x%0d, expected x%0d", $time, idx, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_value(input int idx, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR @%0t: retirement %0d value %h, expected %h", $time, idx, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // every retirement in program order, skipped slots absent
  task automatic load_expected();
    n_exp = 0;
    add_expect(32'h00, 5'd1, 32'd5);
    add_expect(32'h04, 5'd2, 32'hffff_fffd);
    add_expect(32'h08, 5'd3, 32'd2);
    add_expect(32'h0c, 5'd4, 32'd8);
    add_expect(32'h10, 5'd5, 32'h1234_5000);
    add_expect(32'h14, 5'd5, 32'h1234_5678);
    add_expect(32'h18, 5'd6, 32'd8);
    add_expect(32'h1c, 5'd7, 32'hffff_fffd);
    add_expect(32'h20, 5'd8, 32'h1234_567d);
    add_expect(32'h24, 5'd9, 32'hffff_fffb);
    add_expect(32'h28, 5'd0, 32'd0);
    add_expect(32'h2c, 5'd10, 32'd1); // delay slot
    add_expect(32'h38, 5'd0, 32'd0);
    add_expect(32'h3c, 5'd13, 32'd8);
    add_expect(32'h44, 5'd0, 32'd0);
    add_expect(32'h48, 5'd15, 32'd10);
    add_expect(32'h4c, 5'd0, 32'd0);
    add_expect(32'h50, 5'd16, 32'd18);
    add_expect(32'h54, 5'd17, 32'h58); // link
    add_expect(32'h58, 5'd18, 32'd33);
    add_expect(32'h60, 5'd20, 32'h79);
    add_expect(32'h64, 5'd0, 32'd0);
    add_expect(32'h68, 5'd0, 32'd0);
  endtask

  initial begin
    load_expected();
    @(posedge rst_n);
    for (int i = 0; i < NUM_EXP; i++) begin
      do @(negedge clk); while (wb_valid !== 1'b1);
      check_pc(i, wb_pc, exp_pc[i]);
      check_dest(i, wb_dest, exp_dest[i]);
      if (exp_dest[i] != '0) check_value(i, wb_value, exp_value[i]);
    end
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    repeat (16 + NUM_EXP * 40) @(posedge clk);
    $display("timeout: core stopped retiring before the table was done");
    $display("=== FAIL ===");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* list.f */
logic/core_pkg.sv
logic/stage_if.sv
logic/regfile.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_top.sv
test/tb_clock.sv
test/inst_mem.sv
test/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing -Wall --timescale 1ns/1ps
TOP       = core_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
